/* bench/ctr_golden.dat */
// name op data expected_counter expected_alert, all values big-endian hex
// op 2 loads, op 1 increments, ops 0 and 3 are invalid and freeze the counter
load_small 2 0123456789abcdef0011223344556677 0123456789abcdef0011223344556677 0
incr_small 1 00000000000000000000000000000000 0123456789abcdef0011223344556678 0
incr_again 1 00000000000000000000000000000000 0123456789abcdef0011223344556679 0
load_carry48 2 0f0e0d0c0b0a09085678ffffffffffff 0f0e0d0c0b0a09085678ffffffffffff 0
incr_carry48 1 00000000000000000000000000000000 0f0e0d0c0b0a09085679000000000000 0
load_carry112 2 0001ffffffffffffffffffffffffffff 0001ffffffffffffffffffffffffffff 0
incr_carry112 1 00000000000000000000000000000000 00020000000000000000000000000000 0
load_ones 2 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 0
incr_wrap 1 00000000000000000000000000000000 00000000000000000000000000000000 0
incr_from_zero 1 00000000000000000000000000000000 00000000000000000000000000000001 0
load_mid 2 123456789abcdef0fedcba987654ffff 123456789abcdef0fedcba987654ffff 0
incr_mid 1 00000000000000000000000000000000 123456789abcdef0fedcba9876550000 0
bad_op_11 3 deadbeefdeadbeefdeadbeefdeadbeef 123456789abcdef0fedcba9876550000 1

/* tb.f */
verilog/ctr_sparse_pkg.sv
verilog/ctr_data_pkg.sv
verilog/ctr_sparse_chk.sv
verilog/ctr_incr_rail.sv
verilog/ctr_incr.sv
verilog/ctr_host_port.sv
verilog/ctr_core.sv
bench/ctr_core_tb.sv

/* Bender.yml */
package:
  name: ctr_core

sources:
  - verilog/ctr_sparse_pkg.sv
  - verilog/ctr_data_pkg.sv
  - verilog/ctr_sparse_chk.sv
  - verilog/ctr_incr_rail.sv
  - verilog/ctr_incr.sv
  - verilog/ctr_host_port.sv
  - verilog/ctr_core.sv
  - target: test
    files:
      - bench/ctr_core_tb.sv

/* bench/ctr_core_tb.sv */
/* Testbench for the CTR counter stage.
   Runs golden-file commands over the four-phase port and checks the results */
module ctr_core_tb import ctr_sparse_pkg::*, ctr_data_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SliceSize  = 16;
  localparam int unsigned NumSlices  = 8;
  localparam int unsigned Seed       = 2;
  localparam string       GoldenFile = "bench/ctr_golden.dat";

  logic       clk_i;
  logic       reset_i;
  logic       req_i;
  ctr_cmd_t   cmd_i;
  logic       ack_o;
  ctr_block_t ctr_o;
  logic       alert_o;

  // Golden lines
  string        names[$];
  logic [1:0]   ops[$];
  logic [127:0] datas[$];
  logic [127:0] exp_ctrs[$];
  logic         exp_alerts[$];

  int  err_count   = 0;
  int  pass_count  = 0;
  int  fail_count  = 0;
  int  cycle_count = 0;
  int  cycle_limit = 1000;
  logic prev_ack   = 1'b0;
  logic prev_req   = 1'b0;
  bit  file_ok;

  ctr_core #(
    .SliceSize (SliceSize),
    .NumSlices (NumSlices)
  ) ctr_core_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .cmd_i   (cmd_i),
    .ack_o   (ack_o),
    .ctr_o   (ctr_o),
    .alert_o (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Big-endian number to block, byte 0 most significant
  function automatic ctr_block_t num_to_block(logic [127:0] num);
    ctr_block_t blk;
    for (int i = 0; i < CTR_BYTES; i++) begin
      blk[i] = num[8*(CTR_BYTES-1-i) +: 8];
    end
    return blk;
  endfunction

  function automatic logic [127:0] block_to_num(ctr_block_t blk);
    logic [127:0] num;
    for (int i = 0; i < CTR_BYTES; i++) begin
      num[8*(CTR_BYTES-1-i) +: 8] = blk[i];
    end
    return num;
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic load_golden(output bit ok);
    int           fd;
    int           n;
    string        line;
    string        name;
    logic [1:0]   op;
    logic [127:0] data;
    logic [127:0] exp_ctr;
    logic         exp_alert;
    ok = 1'b1;
    fd = $fopen(GoldenFile, "r");
    if (fd == 0) begin
      $display("Golden file %s could not be opened", GoldenFile);
      ok = 1'b0;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comments and blank lines
      if (line.len() < 2 || line[0] == "/") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h", name, op, data, exp_ctr, exp_alert);
      if (n != 5) begin
        $display("Golden file line could not be parsed: %s", line);
        ok = 1'b0;
      end else begin
        names.push_back(name);
        ops.push_back(op);
        datas.push_back(data);
        exp_ctrs.push_back(exp_ctr);
        exp_alerts.push_back(exp_alert);
      end
    end
    $fclose(fd);
    if (names.size() == 0) begin
      ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      fail_count++;
      $display("[%0t] %s: mismatch", $time, name);
    end
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = err_count;
    @(negedge clk_i);
    check_value("reset counter", block_to_num(ctr_o), '0);
    check_value("reset ack_o", ack_o, 1'b0);
    check_value("reset alert_o", alert_o, 1'b0);
    finish_test("reset", errs_before);
  endtask

  // One four-phase cycle for golden line idx
  task automatic run_line(input int idx);
    int   gap;
    int   errs_before;
    logic acked;
    errs_before = err_count;
    gap = $urandom % 4;
    repeat (gap) @(posedge clk_i);
    @(posedge clk_i);
    cmd_i.op   <= ops[idx];
    cmd_i.data <= num_to_block(datas[idx]);
    req_i      <= 1'b1;
    // Done on ack, or on alert for a bad op
    do begin
      @(negedge clk_i);
    end while (!ack_o && !alert_o);
    acked = ack_o;
    check_value({names[idx], " counter"}, block_to_num(ctr_o), exp_ctrs[idx]);
    check_value({names[idx], " alert_o"}, alert_o, exp_alerts[idx]);
    check_value({names[idx], " ack_o"}, acked, !exp_alerts[idx]);
    @(posedge clk_i);
    req_i <= 1'b0;
    if (acked) begin
      do begin
        @(negedge clk_i);
      end while (ack_o);
    end
    finish_test(names[idx], errs_before);
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  // Four-phase rules, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      // ack_o only rises on a pending request
      if (ack_o && !prev_ack) begin
        check_value("req_i at ack_o rise", req_i, 1'b1);
      end
      // ack_o only falls once the request is gone
      if (!ack_o && prev_ack) begin
        check_value("req_i at ack_o fall", req_i, 1'b0);
      end
      // One cycle of grace after req_i falls
      if (!req_i && !prev_req) begin
        check_value("ack_o after req_i fell", ack_o, 1'b0);
      end
      prev_ack = ack_o;
      prev_req = req_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d clock cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(Seed));
    reset_i = 1'b1;
    req_i   = 1'b0;
    cmd_i   = '0;
    load_golden(file_ok);
    // Reset counts as one extra line
    cycle_limit = (names.size() + 1) * (NumSlices + 10);
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    if (file_ok) begin
      check_reset();
      for (int i = 0; i < names.size(); i++) begin
        run_line(i);
      end
    end else begin
      $display("No tests were run, the golden file is missing or unreadable");
      err_count++;
    end
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/ctr_core.sv */
/* CTR counter stage top level.
   Host port and slice-wise incrementer, slicing set here */
module ctr_core import ctr_sparse_pkg::*, ctr_data_pkg::*; #(
  parameter int unsigned SliceSize = SLICE_SIZE_DEF,
  parameter int unsigned NumSlices = NUM_SLICES_DEF
) (
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       req_i,
  input  ctr_cmd_t   cmd_i,
  output logic       ack_o,

  output ctr_block_t ctr_o,
  output logic       alert_o
);

  // Host port to incrementer
  sp2v_t                 incr;
  sp2v_t                 ready;
  ctr_block_t            ctr_next;
  sp2v_t [NumSlices-1:0] ctr_we;

  ctr_host_port #(
    .SliceSize (SliceSize),
    .NumSlices (NumSlices)
  ) host_port_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .cmd_i      (cmd_i),
    .ack_o      (ack_o),
    .incr_o     (incr),
    .ready_i    (ready),
    .alert_i    (alert_o),
    .ctr_o      (ctr_o),
    .ctr_next_i (ctr_next),
    .ctr_we_i   (ctr_we)
  );

  // Sticky alert, also halts the host port
  ctr_incr #(
    .SliceSize (SliceSize),
    .NumSlices (NumSlices)
  ) incr_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .incr_i   (incr),
    .ready_o  (ready),
    .alert_o  (alert_o),
    .ctr_i    (ctr_o),
    .ctr_o    (ctr_next),
    .ctr_we_o (ctr_we)
  );

endmodule

/* verilog/ctr_host_port.sv */
/* Four-phase req/ack host port of the CTR counter stage.
   Holds the counter register and sequences load and increment */
module ctr_host_port import ctr_sparse_pkg::*, ctr_data_pkg::*; #(
  parameter int unsigned SliceSize = SLICE_SIZE_DEF,
  parameter int unsigned NumSlices = NUM_SLICES_DEF
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Host side
  input  logic                  req_i,
  input  ctr_cmd_t              cmd_i,
  output logic                  ack_o,

  // Incrementer side
  output sp2v_t                 incr_o,
  input  sp2v_t                 ready_i,
  input  logic                  alert_i,
  output ctr_block_t            ctr_o,
  input  ctr_block_t            ctr_next_i,
  input  sp2v_t [NumSlices-1:0] ctr_we_i
);

  typedef logic [SliceSize-1:0]   slice_t;
  typedef slice_t [NumSlices-1:0] slice_vec_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    RUN,
    WAIT_READY,
    ACK,
    HALT
  } port_state_e;

  port_state_e state_q;
  port_state_e state_d;

  // Counter register, viewed per slice
  slice_vec_t ctr_q;
  slice_vec_t ctr_next;

  assign ctr_next = slice_vec_t'(ctr_next_i);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    incr_o  = SP2V_LOW;

    case (state_q)
      IDLE: begin
        // Low is load, anything else goes to the incrementer
        if (req_i) begin
          state_d = (cmd_i.op == SP2V_LOW) ? LOAD : RUN;
        end
      end

      LOAD: begin
        state_d = ACK;
      end

      RUN: begin
        // Raw op for exactly one cycle, checked downstream
        incr_o  = cmd_i.op;
        state_d = WAIT_READY;
      end

      WAIT_READY: begin
        if (ready_i == SP2V_HIGH) begin
          state_d = ACK;
        end
      end

      ACK: begin
        if (!req_i) begin
          state_d = IDLE;
        end
      end

      HALT: begin
        // Stuck until reset
        state_d = HALT;
      end

      default: begin
        state_d = HALT;
      end
    endcase

    if (alert_i) begin
      state_d = HALT;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ack_o = (state_q == ACK);

  ////////////////////
  // Counter register
  ////////////////////

  // Whole block on load, single slices during an increment
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctr_q <= '0;
    end else if (state_q == LOAD) begin
      ctr_q <= slice_vec_t'(cmd_i.data);
    end else begin
      for (int k = 0; k < NumSlices; k++) begin
        if (ctr_we_i[k] == SP2V_HIGH) begin
          ctr_q[k] <= ctr_next[k];
        end
      end
    end
  end

  assign ctr_o = ctr_block_t'(ctr_q);

endmodule

/* verilog/ctr_incr.sv */
/* CTR incrementer, adds one to the 128-bit block one slice per cycle.
   Two redundant rails run the FSM; disagreement raises the alert */
module ctr_incr import ctr_sparse_pkg::*, ctr_data_pkg::*; #(
  parameter int unsigned SliceSize = SLICE_SIZE_DEF,
  parameter int unsigned NumSlices = NUM_SLICES_DEF
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  sp2v_t                 incr_i,
  output sp2v_t                 ready_o,
  output logic                  alert_o,

  input  ctr_block_t            ctr_i,
  output ctr_block_t            ctr_o,
  output sp2v_t [NumSlices-1:0] ctr_we_o
);

  localparam int unsigned IdxW = slice_idx_w(NumSlices);

  typedef logic [IdxW-1:0]        slice_idx_t;
  typedef logic [SliceSize-1:0]   slice_t;
  typedef slice_t [NumSlices-1:0] slice_vec_t;
  typedef sp2v_t [NumSlices-1:0]  slice_we_t;

  // Byte 0 to the top, so slice 0 ends up least significant
  function automatic ctr_block_t rev_bytes(ctr_block_t blk);
    ctr_block_t res;
    for (int i = 0; i < CTR_BYTES; i++) begin
      res[i] = blk[CTR_BYTES-1-i];
    end
    return res;
  endfunction

  // Slice order flip for the write enables
  function automatic slice_we_t rev_we(slice_we_t we);
    slice_we_t res;
    for (int i = 0; i < NumSlices; i++) begin
      res[i] = we[NumSlices-1-i];
    end
    return res;
  endfunction

  slice_vec_t ctr_i_rev;
  slice_vec_t ctr_o_rev;
  slice_we_t  we_rev;

  sp2v_t      incr_chk;
  logic       incr_err;
  logic       mr_err;

  slice_idx_t slice_idx;
  slice_t     slice_in;
  slice_t     slice_out;

  // One bit per rail, each in that rail's own polarity
  logic [SP2V_WIDTH-1:0] sp_incr;
  logic [SP2V_WIDTH-1:0] sp_ready;
  logic [SP2V_WIDTH-1:0] sp_we;
  logic [SP2V_WIDTH-1:0] mr_alert;

  // Multi-bit rail outputs, OR-combined below
  slice_idx_t [SP2V_WIDTH-1:0] mr_idx;
  slice_t     [SP2V_WIDTH-1:0] mr_slice;

  ////////////////////
  // Input side
  ////////////////////

  assign ctr_i_rev = slice_vec_t'(rev_bytes(ctr_i));

  ctr_sparse_chk sparse_chk_inst (
    .sel_i (incr_i),
    .sel_o (incr_chk),
    .err_o (incr_err)
  );

  assign sp_incr  = incr_chk;

  // Both rails see the same slice
  assign slice_in = ctr_i_rev[slice_idx];

  ////////////////////
  // Redundant rails
  ////////////////////

  for (genvar r = 0; r < SP2V_WIDTH; r++) begin : gen_rail
    ctr_incr_rail #(
      .Polarity  (rail_pol_of(r)),
      .SliceSize (SliceSize),
      .NumSlices (NumSlices)
    ) rail_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .incr_i      (sp_incr[r]),
      .ready_o     (sp_ready[r]),
      .incr_err_i  (incr_err),
      .mr_err_i    (mr_err),
      .alert_o     (mr_alert[r]),
      .slice_idx_o (mr_idx[r]),
      .slice_i     (slice_in),
      .slice_o     (mr_slice[r]),
      .we_o        (sp_we[r])
    );
  end

  assign ready_o = sp_ready;
  // Either rail in error is enough
  assign alert_o = |mr_alert;

  // Index combine kept apart from the slice path
  always_comb begin
    slice_idx = '0;
    for (int r = 0; r < SP2V_WIDTH; r++) begin
      slice_idx |= mr_idx[r];
    end
  end

  // Slice combine, then check each rail against the combined value
  always_comb begin
    slice_out = '0;
    mr_err    = 1'b0;
    for (int r = 0; r < SP2V_WIDTH; r++) begin
      slice_out |= mr_slice[r];
    end
    for (int r = 0; r < SP2V_WIDTH; r++) begin
      if ((mr_idx[r] != slice_idx) || (mr_slice[r] != slice_out)) begin
        mr_err = 1'b1;
      end
    end
  end

  ////////////////////
  // Output side
  ////////////////////

  // Untouched slices pass through
  always_comb begin
    ctr_o_rev            = ctr_i_rev;
    ctr_o_rev[slice_idx] = slice_out;
  end

  // At most one slice enabled, all others low
  always_comb begin
    we_rev            = {NumSlices{SP2V_LOW}};
    we_rev[slice_idx] = sp_we;
  end

  assign ctr_o    = rev_bytes(ctr_block_t'(ctr_o_rev));
  assign ctr_we_o = rev_we(we_rev);

endmodule

/* verilog/ctr_incr_rail.sv */
/* Single rail of the slice-wise CTR increment FSM.
   Built in true or inverted polarity; two rails make one sparse FSM */
module ctr_incr_rail import ctr_sparse_pkg::*, ctr_data_pkg::*; #(
  parameter rail_pol_e   Polarity  = RAIL_POS,
  parameter int unsigned SliceSize = SLICE_SIZE_DEF,
  parameter int unsigned NumSlices = NUM_SLICES_DEF
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  input  logic                                 incr_i,
  output logic                                 ready_o,
  input  logic                                 incr_err_i,
  input  logic                                 mr_err_i,
  output logic                                 alert_o,

  output logic [slice_idx_w(NumSlices)-1:0]    slice_idx_o,
  input  logic [SliceSize-1:0]                 slice_i,
  output logic [SliceSize-1:0]                 slice_o,
  output logic                                 we_o
);

  localparam int unsigned IdxW = slice_idx_w(NumSlices);

  typedef logic [IdxW-1:0]      slice_idx_t;
  typedef logic [SliceSize-1:0] slice_t;

  typedef enum logic [1:0] {
    IDLE,
    INCR,
    ERROR
  } rail_state_e;

  // Last slice index, highest significance
  localparam slice_idx_t IdxLast = slice_idx_t'(NumSlices - 1);

  rail_state_e state_q;
  rail_state_e state_d;
  slice_idx_t  idx_q;
  slice_idx_t  idx_d;
  slice_t      slice_inc;

  // Rail-internal signals, always true polarity
  logic incr;
  logic ready;
  logic we;

  assign incr      = rail_map(Polarity, incr_i);
  assign slice_inc = slice_i + 1'b1;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    ready   = 1'b0;
    we      = 1'b0;
    alert_o = 1'b0;
    slice_o = slice_i;

    case (state_q)
      IDLE: begin
        ready = 1'b1;
        // Start from the least significant slice
        if (incr) begin
          idx_d   = '0;
          state_d = INCR;
        end
      end

      INCR: begin
        slice_o = slice_inc;
        we      = 1'b1;
        // Carry only while the slice wraps to zero
        if ((slice_inc != '0) || (idx_q == IdxLast)) begin
          idx_d   = '0;
          state_d = IDLE;
        end else begin
          idx_d = idx_q + 1'b1;
        end
      end

      ERROR: begin
        // Terminal, left only by reset
        alert_o = 1'b1;
      end

      default: begin
        state_d = ERROR;
      end
    endcase

    // Bad command or rail disagreement, no write in this cycle
    if (incr_err_i || mr_err_i) begin
      state_d = ERROR;
      ready   = 1'b0;
      we      = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  // Back to code polarity of this rail
  assign ready_o     = rail_map(Polarity, ready);
  assign we_o        = rail_map(Polarity, we);
  assign slice_idx_o = idx_q;

endmodule

/* verilog/ctr_sparse_chk.sv */
/* Sparse code check, purely combinational.
   Forwards valid codes, turns invalid ones into low and flags them */
module ctr_sparse_chk import ctr_sparse_pkg::*; (
  input  sp2v_t sel_i,
  output sp2v_t sel_o,
  output logic  err_o
);

  logic sel_ok;

  // Only 01 and 10 are legal
  assign sel_ok = sp2v_valid(sel_i);

  always_comb begin
    sel_o = SP2V_LOW;
    err_o = 1'b0;
    if (sel_ok) begin
      // High or low passes unchanged
      sel_o = sel_i;
    end else begin
      // 00 or 11
      // Forced low so that neither rail starts an increment
      sel_o = SP2V_LOW;
      err_o = 1'b1;
    end
  end

endmodule

/* verilog/ctr_data_pkg.sv */
/* Counter block widths, slicing defaults and the host command
   format of the CTR counter stage */
package ctr_data_pkg;

  import ctr_sparse_pkg::*;

  ////////////////////
  // Counter block
  ////////////////////

  // 128-bit counter block, one AES state
  localparam int unsigned CTR_BYTES = 16;
  localparam int unsigned CTR_WIDTH = CTR_BYTES * 8;

  typedef logic [7:0] ctr_byte_t;

  // Byte i sits at bits [8i+7:8i]
  // Byte 0 is the most significant byte of the CTR number (big-endian)
  typedef ctr_byte_t [CTR_BYTES-1:0] ctr_block_t;

  ////////////////////
  // Slicing
  ////////////////////

  // Default slicing, 8 slices of 16 bits
  // SliceSize must be a multiple of 8 and divide CTR_WIDTH
  localparam int unsigned SLICE_SIZE_DEF = 16;
  localparam int unsigned NUM_SLICES_DEF = CTR_WIDTH / SLICE_SIZE_DEF;

  // Width of a slice index, at least one bit
  function automatic int unsigned slice_idx_w(int unsigned num_slices);
    return (num_slices > 1) ? $clog2(num_slices) : 1;
  endfunction

  ////////////////////
  // Host command
  ////////////////////

  // op low loads data, op high increments
  // Any other op code is invalid and trips the alert
  typedef struct packed {
    sp2v_t      op;
    ctr_block_t data;
  } ctr_cmd_t;

endpackage

/* verilog/ctr_sparse_pkg.sv */
/* Sparse two-bit encodings for the CTR counter stage,
   plus the polarity helpers used by the redundant FSM rails */
package ctr_sparse_pkg;

  ////////////////////
  // Sparse values
  ////////////////////

  // Two rails, one per code bit
  localparam int unsigned SP2V_WIDTH = 2;

  typedef logic [SP2V_WIDTH-1:0] sp2v_t;

  // 00 and 11 are never produced on purpose
  localparam sp2v_t SP2V_HIGH = 2'b01;
  localparam sp2v_t SP2V_LOW  = 2'b10;

  // Valid means exactly one of the two legal codes
  function automatic logic sp2v_valid(sp2v_t val);
    return (val == SP2V_HIGH) || (val == SP2V_LOW);
  endfunction

  ////////////////////
  // Rail polarity
  ////////////////////

  typedef enum logic {
    RAIL_POS,
    RAIL_NEG
  } rail_pol_e;

  // Bit set in the high code runs true polarity, the other bit inverted
  function automatic rail_pol_e rail_pol_of(int unsigned bit_idx);
    return SP2V_HIGH[bit_idx] ? RAIL_POS : RAIL_NEG;
  endfunction

  // Maps between rail-internal true logic and the code bit of that rail
  function automatic logic rail_map(rail_pol_e pol, logic val);
    return (pol == RAIL_NEG) ? ~val : val;
  endfunction

endpackage
